// File: logic/bus_pkg.sv
package bus_pkg;

    localparam int DAT_W = 8;
    localparam int ADR_W = 32;

    typedef logic [DAT_W-1:0] dat8_t;
    typedef logic [ADR_W-1:0] adr_t;

    // region nibble at the top of the address
    localparam int REGION_MSB = 31;
    localparam int REGION_LSB = 28;
    localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

    typedef logic [REGION_W-1:0] region_t;

    // only region F is the led block, the rest is ram
    localparam region_t REGION_LEDS = 4'hF;

    function automatic region_t region_of(input adr_t adr);
        return adr[REGION_MSB:REGION_LSB];
    endfunction

    function automatic logic is_led_region(input adr_t adr);
        return region_of(adr) == REGION_LEDS;
    endfunction

endpackage

// File: logic/periph_pkg.sv
package periph_pkg;

    localparam int RAM_DEPTH = 1024;
    localparam int RAM_AW    = $clog2(RAM_DEPTH);

    typedef logic [7:0] led_t;
    typedef logic [7:0] period_t;

    // register offset from adr[1:0]
    localparam int LED_REG_AW = 2;

    typedef logic [LED_REG_AW-1:0] led_reg_t;

    localparam led_reg_t LED_REG_VALUE  = 2'd0;
    localparam led_reg_t LED_REG_CTRL   = 2'd1;
    localparam led_reg_t LED_REG_PERIOD = 2'd2;

    typedef struct packed {
        logic [6:0] reserved;
        logic       blink_en;
    } led_ctrl_t;

    localparam led_ctrl_t LED_CTRL_RESET = '0;

    // reserved bits never get stored
    function automatic led_ctrl_t ctrl_from_byte(input logic [7:0] b);
        led_ctrl_t c;
        c = LED_CTRL_RESET;
        c.blink_en = b[0];
        return c;
    endfunction

endpackage

// File: logic/wb8_if.sv
interface wb8_if
    import bus_pkg::*;
();

    logic  cyc;
    logic  stb;
    logic  we;
    adr_t  adr;
    dat8_t dat_w;
    dat8_t dat_r;
    logic  ack;

    // request side
    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    // response side
    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

// File: logic/wb_decoder.sv
module wb_decoder
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    wb8_if.slave  m,
    wb8_if.master ram,
    wb8_if.master led
);

    // clk and rst are the clock and reset of the bound protocol checks
    logic sel_led;

    assign sel_led = is_led_region(m.adr);

    // request lines fan out to both slaves
    assign ram.cyc   = m.cyc;
    assign ram.we    = m.we;
    assign ram.adr   = m.adr;
    assign ram.dat_w = m.dat_w;

    assign led.cyc   = m.cyc;
    assign led.we    = m.we;
    assign led.adr   = m.adr;
    assign led.dat_w = m.dat_w;

    // strobe only the addressed slave
    assign ram.stb = m.stb & ~sel_led;
    assign led.stb = m.stb & sel_led;

    // response back from the selected slave
    always_comb begin
        if (sel_led) begin
            m.dat_r = led.dat_r;
            m.ack   = led.ack;
        end else begin
            m.dat_r = ram.dat_r;
            m.ack   = ram.ack;
        end
    end

endmodule

// File: logic/ram1k_wb8.sv
module ram1k_wb8
    import bus_pkg::*;
    import periph_pkg::*;
(
    input  logic clk,
    input  logic rst,
    wb8_if.slave bus
);

    dat8_t mem [RAM_DEPTH];

    logic [RAM_AW-1:0] word_adr;
    logic              access;

    // upper address bits ignored, contents repeat every 1 KiB
    assign word_adr = bus.adr[RAM_AW-1:0];

    // new request not yet acknowledged
    assign access = bus.cyc & bus.stb & ~bus.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    // write lands on the edge that raises ack
    always_ff @(posedge clk) begin
        if (access && bus.we) begin
            mem[word_adr] <= bus.dat_w;
        end
    end

    // read data valid in the ack cycle
    always_ff @(posedge clk) begin
        if (access) begin
            bus.dat_r <= mem[word_adr];
        end
    end

endmodule

// File: logic/leds_wb8.sv
module leds_wb8
    import bus_pkg::*;
    import periph_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    wb8_if.slave    bus,
    output led_t    led_value,
    output logic    blink_en,
    output period_t period
);

    led_ctrl_t ctrl;
    led_reg_t  reg_sel;
    logic      access;
    logic      wr;
    dat8_t     rd_data;

    assign reg_sel = bus.adr[LED_REG_AW-1:0];
    assign access  = bus.cyc & bus.stb & ~bus.ack;
    assign wr      = access & bus.we;

    // register writes, same edge as ack
    always_ff @(posedge clk) begin
        if (rst) begin
            led_value <= '0;
            ctrl      <= LED_CTRL_RESET;
            period    <= '0;
        end else if (wr) begin
            case (reg_sel)
                LED_REG_VALUE: begin
                    led_value <= bus.dat_w;
                end
                LED_REG_CTRL: begin
                    ctrl <= ctrl_from_byte(bus.dat_w);
                end
                LED_REG_PERIOD: begin
                    period <= bus.dat_w;
                end
                default: begin
                end
            endcase
        end
    end

    // readback, offset 3 is empty
    always_comb begin
        case (reg_sel)
            LED_REG_VALUE:  rd_data = led_value;
            LED_REG_CTRL:   rd_data = ctrl;
            LED_REG_PERIOD: rd_data = period;
            default:        rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            bus.dat_r <= rd_data;
        end
    end

    assign blink_en = ctrl.blink_en;

endmodule

// File: logic/led_blinker.sv
module led_blinker
    import periph_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  led_t    led_value,
    input  logic    blink_en,
    input  period_t period,
    output led_t    leds
);

    period_t cnt;
    logic    phase;
    logic    blink_en_q;
    logic    start;
    period_t cnt_now;
    logic    phase_now;

    // enable edge restarts the pattern in that same cycle
    assign start     = blink_en & ~blink_en_q;
    assign cnt_now   = start ? period_t'(0) : cnt;
    assign phase_now = start | phase;

    // prescaler wraps after period+1 cycles and flips the phase
    always_ff @(posedge clk) begin
        if (rst) begin
            blink_en_q <= 1'b0;
            cnt        <= '0;
            phase      <= 1'b1;
        end else begin
            blink_en_q <= blink_en;
            if (blink_en) begin
                if (cnt_now == period) begin
                    cnt   <= '0;
                    phase <= ~phase_now;
                end else begin
                    cnt   <= cnt_now + 1'b1;
                    phase <= phase_now;
                end
            end
        end
    end

    // dark only in phase 0 while blinking
    assign leds = (!blink_en || phase_now) ? led_value : '0;

endmodule

// File: logic/soc_top.sv
module soc_top
    import bus_pkg::*;
    import periph_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  cyc,
    input  logic  stb,
    input  logic  we,
    input  adr_t  adr,
    input  dat8_t dat_w,
    output dat8_t dat_r,
    output logic  ack,
    output led_t  leds
);

    wb8_if m_bus ();
    wb8_if ram_bus ();
    wb8_if led_bus ();

    led_t    led_value;
    logic    blink_en;
    period_t period;

    // master side comes from the top ports
    assign m_bus.cyc   = cyc;
    assign m_bus.stb   = stb;
    assign m_bus.we    = we;
    assign m_bus.adr   = adr;
    assign m_bus.dat_w = dat_w;
    assign dat_r       = m_bus.dat_r;
    assign ack         = m_bus.ack;

    wb_decoder i_decoder (
        .clk (clk),
        .rst (rst),
        .m   (m_bus.slave),
        .ram (ram_bus.master),
        .led (led_bus.master)
    );

    ram1k_wb8 i_ram (
        .clk (clk),
        .rst (rst),
        .bus (ram_bus.slave)
    );

    leds_wb8 i_leds (
        .clk       (clk),
        .rst       (rst),
        .bus       (led_bus.slave),
        .led_value (led_value),
        .blink_en  (blink_en),
        .period    (period)
    );

    led_blinker i_blinker (
        .clk       (clk),
        .rst       (rst),
        .led_value (led_value),
        .blink_en  (blink_en),
        .period    (period),
        .leds      (leds)
    );

endmodule

// File: sim/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: sim/soc_sva.sv
module soc_sva (
    input logic clk,
    input logic rst,
    input logic m_stb,
    input logic m_ack,
    input logic ram_stb,
    input logic led_stb
);

    // failed assertions so far
    int fail_count = 0;

    // ack answers a strobe seen one edge earlier
    ack_after_stb: assert property (
        @(posedge clk) disable iff (rst) $rose(m_ack) |-> $past(m_stb)
    ) else begin
        $error("ack rose without a strobe before it");
        fail_count++;
    end

    ack_one_cycle: assert property (
        @(posedge clk) disable iff (rst) m_ack |=> !m_ack
    ) else begin
        $error("ack held for more than one cycle");
        fail_count++;
    end

    stb_one_slave: assert property (
        @(posedge clk) disable iff (rst) !(ram_stb && led_stb)
    ) else begin
        $error("ram and led strobes high together");
        fail_count++;
    end

endmodule

// File: sim/soc_tb.sv
module soc_tb
    import bus_pkg::*;
    import periph_pkg::*;
();

    // about 200 bus accesses of 3 cycles plus the blink run, with margin
    localparam int TIMEOUT_CYCLES = 6000;
    localparam adr_t LED_BASE = 32'hF000_0000;

    logic   clk;
    logic   rst;
    logic   cyc;
    logic   stb;
    logic   we;
    adr_t   adr;
    dat8_t  dat_w;
    dat8_t  dat_r;
    logic   ack;
    led_t   leds;
    integer seed = 32'he7c1;
    int     errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     cycles = 0;
    adr_t   ram_adr [32];
    dat8_t  ram_dat [32];

    tb_clock #(.PERIOD(40)) i_clock (.clk(clk));

    soc_top i_dut (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .leds  (leds)
    );

    bind wb_decoder soc_sva i_sva (
        .clk     (clk),
        .rst     (rst),
        .m_stb   (m.stb),
        .m_ack   (m.ack),
        .ram_stb (ram.stb),
        .led_stb (led.stb)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic check_dat(input string name, input dat8_t got, input dat8_t exp);
        if (got !== exp) begin
            report_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_leds(input string name, input led_t got, input led_t exp);
        if (got !== exp) begin
            report_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    // one handshake, returns on the falling edge inside the ack cycle
    task automatic bus_cycle(input logic write, input adr_t a, input dat8_t d,
                             output dat8_t q);
        int waited;
        @(negedge clk);
        if (ack !== 1'b0) report_error($sformatf("ack high on idle bus before %h", a));
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = a;
        dat_w = d;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (ack !== 1'b1 && waited < 4);
        if (ack !== 1'b1) report_error($sformatf("no ack within 4 cycles for %h", a));
        else if (waited != 1) report_error($sformatf("ack %0d cycles after stb", waited));
        q   = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic bus_write(input adr_t a, input dat8_t d);
        dat8_t unused;
        bus_cycle(1'b1, a, d, unused);
    endtask

    task automatic bus_read(input adr_t a, output dat8_t q);
        bus_cycle(1'b0, a, '0, q);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_reset();
        int    e;
        dat8_t q;
        e = errors;
        repeat (4) begin
            @(negedge clk);
            if (ack !== 1'b0) report_error("ack high after reset");
            check_leds("leds", leds, '0);
        end
        for (int i = 0; i < 3; i++) begin
            bus_read(LED_BASE | adr_t'(i), q);
            check_dat("dat_r", q, '0);
        end
        report_test("reset", e);
    endtask

    task automatic test_ram();
        int    e;
        adr_t  r;
        dat8_t q;
        dat8_t x;
        e = errors;
        // distinct words below 0x210, any region but F
        for (int i = 0; i < 32; i++) begin
            r = adr_t'($random(seed));
            if (r[31:28] == REGION_LEDS) r[31:28] = 4'h0;
            r[9:4] = 6'(i + 1);
            ram_adr[i] = r;
            ram_dat[i] = dat8_t'($random(seed));
            bus_write(ram_adr[i], ram_dat[i]);
        end
        for (int i = 0; i < 32; i++) begin
            bus_read(ram_adr[i], q);
            check_dat("dat_r", q, ram_dat[i]);
        end
        x = dat8_t'($random(seed));
        bus_write(32'h0000_0300, x);
        bus_read(32'h0000_0700, q);
        check_dat("dat_r", q, x);
        x = dat8_t'($random(seed));
        bus_write(32'h3000_0280, x);
        bus_read(32'h3000_0280, q);
        check_dat("dat_r", q, x);
        report_test("ram", e);
    endtask

    task automatic test_led_value();
        int    e;
        led_t  v;
        dat8_t q;
        e = errors;
        v = led_t'($random(seed));
        // ram word 0 sits under the led register offsets
        bus_write(32'h0000_0000, 8'h96);
        bus_write(LED_BASE, v);
        check_leds("leds", leds, v);
        bus_read(LED_BASE, q);
        check_dat("dat_r", q, v);
        bus_read(32'h0000_0000, q);
        check_dat("dat_r", q, 8'h96);
        for (int i = 0; i < 32; i++) begin
            bus_read(ram_adr[i], q);
            check_dat("dat_r", q, ram_dat[i]);
        end
        report_test("led_value", e);
    endtask

    task automatic test_registers();
        int      e;
        period_t p;
        dat8_t   q;
        e = errors;
        bus_write(LED_BASE | 32'd1, 8'hFE);
        bus_read(LED_BASE | 32'd1, q);
        check_dat("dat_r", q, 8'h00);
        bus_write(LED_BASE | 32'd1, 8'hA5);
        bus_read(LED_BASE | 32'd1, q);
        check_dat("dat_r", q, 8'h01);
        bus_write(LED_BASE | 32'd1, 8'h00);
        p = period_t'($random(seed));
        bus_write(LED_BASE | 32'd2, p);
        bus_read(LED_BASE | 32'd2, q);
        check_dat("dat_r", q, p);
        bus_write(LED_BASE | 32'd3, 8'h5A);
        bus_read(LED_BASE | 32'd3, q);
        check_dat("dat_r", q, 8'h00);
        report_test("registers", e);
    endtask

    task automatic test_blink();
        int      e;
        int      half;
        led_t    v;
        period_t p;
        e = errors;
        v = led_t'($random(seed)) | 8'h01;
        bus_write(LED_BASE, v);
        for (int k = 0; k < 3; k++) begin
            if (k < 2) p = period_t'(k);
            else p = period_t'(16 + ($random(seed) & 31));
            half = int'(p) + 1;
            bus_write(LED_BASE | 32'd2, p);
            bus_write(LED_BASE | 32'd1, 8'h01);
            // first sample is the ack cycle of the enable write
            for (int n = 0; n < 6 * half; n++) begin
                check_leds("leds", leds, ((n / half) % 2 == 0) ? v : '0);
                @(negedge clk);
            end
            bus_write(LED_BASE | 32'd1, 8'h00);
            repeat (2 * half + 2) begin
                check_leds("leds", leds, v);
                @(negedge clk);
            end
        end
        report_test("blink", e);
    endtask

    initial begin
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_ram();
        test_led_value();
        test_registers();
        test_blink();
        if (i_dut.i_decoder.i_sva.fail_count != 0) begin
            report_error($sformatf("%0d bus protocol assertions failed",
                                   i_dut.i_decoder.i_sva.fail_count));
        end
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/bus_pkg.sv
logic/periph_pkg.sv
logic/wb8_if.sv
logic/wb_decoder.sv
logic/ram1k_wb8.sv
logic/leds_wb8.sv
logic/led_blinker.sv
logic/soc_top.sv
sim/tb_clock.sv
sim/soc_sva.sv
sim/soc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard logic/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/$(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
